//--- xadc_params.svh
`ifndef XADC_PARAMS_SVH
`define XADC_PARAMS_SVH

// DRP bus widths of the XADC primitive
`define XADC_DRP_DATA_WIDTH 16
`define XADC_DRP_ADDR_WIDTH 7

// Status register addresses of the two auxiliary inputs
// VAUXP3/VAUXN3 carries the supply voltage divider
`define XADC_ADDR_VOLTAGE 7'h13

// VAUXP11/VAUXN11 carries the current-monitor output
`define XADC_ADDR_CURRENT 7'h1B

// Entries per channel FIFO
// Must be a power of two, at least 2
`define XADC_FIFO_DEPTH 4

`endif

//--- xadc_drp_pkg.sv
`include "xadc_params.svh"

package xadc_drp_pkg;

    // Addresses the sequencer drives on daddr
    typedef enum logic [`XADC_DRP_ADDR_WIDTH-1:0] {
        addr_voltage = `XADC_ADDR_VOLTAGE,
        addr_current = `XADC_ADDR_CURRENT
    } drp_addr_t;

    // One read pair per eos
    // Each channel goes request, wait for drdy, then send to its FIFO
    typedef enum logic [2:0] {
        seq_idle,
        seq_voltage_req,
        seq_voltage_wait,
        seq_voltage_send,
        seq_current_req,
        seq_current_wait,
        seq_current_send
    } seq_state_t;

endpackage

//--- xadc_stream_pkg.sv
`include "xadc_params.svh"

package xadc_stream_pkg;

    // Raw DRP status word as read from the XADC
    // The 12-bit code sits left aligned, low bits are unused
    typedef logic [`XADC_DRP_DATA_WIDTH-1:0] sample_t;

endpackage

//--- xadc_drp_sequencer.sv
`timescale 1ns/100ps

module xadc_drp_sequencer (
    input  logic                     xadc_dclk,
    input  logic                     arst_n,

    input  logic                     xadc_eos,
    input  logic                     xadc_drdy,
    input  xadc_stream_pkg::sample_t xadc_do,
    output xadc_drp_pkg::drp_addr_t  xadc_daddr,
    output logic                     xadc_den,

    output xadc_stream_pkg::sample_t voltage_sample,
    output logic                     voltage_valid,
    input  logic                     voltage_ready,

    output xadc_stream_pkg::sample_t current_sample,
    output logic                     current_valid,
    input  logic                     current_ready
);

    xadc_drp_pkg::seq_state_t state;
    xadc_drp_pkg::seq_state_t state_next;
    logic                     voltage_xfer;
    logic                     current_xfer;

    assign voltage_xfer = voltage_valid && voltage_ready;
    assign current_xfer = current_valid && current_ready;

    // eos only counts in idle, pulses during a read pair are dropped
    always_comb begin
        state_next = state;
        case (state)
            xadc_drp_pkg::seq_idle: begin
                if (xadc_eos) begin
                    state_next = xadc_drp_pkg::seq_voltage_req;
                end
            end
            xadc_drp_pkg::seq_voltage_req: begin
                state_next = xadc_drp_pkg::seq_voltage_wait;
            end
            xadc_drp_pkg::seq_voltage_wait: begin
                if (xadc_drdy) begin
                    state_next = xadc_drp_pkg::seq_voltage_send;
                end
            end
            xadc_drp_pkg::seq_voltage_send: begin
                if (voltage_xfer) begin
                    state_next = xadc_drp_pkg::seq_current_req;
                end
            end
            xadc_drp_pkg::seq_current_req: begin
                state_next = xadc_drp_pkg::seq_current_wait;
            end
            xadc_drp_pkg::seq_current_wait: begin
                if (xadc_drdy) begin
                    state_next = xadc_drp_pkg::seq_current_send;
                end
            end
            xadc_drp_pkg::seq_current_send: begin
                if (current_xfer) begin
                    state_next = xadc_drp_pkg::seq_idle;
                end
            end
            default: begin
                state_next = xadc_drp_pkg::seq_idle;
            end
        endcase
    end

    // Outputs decoded from the next state so they line up with it
    always_ff @(posedge xadc_dclk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= xadc_drp_pkg::seq_idle;
            xadc_den      <= 1'b0;
            xadc_daddr    <= xadc_drp_pkg::addr_voltage;
            voltage_valid <= 1'b0;
            current_valid <= 1'b0;
        end else begin
            state         <= state_next;
            xadc_den      <= (state_next == xadc_drp_pkg::seq_voltage_req) ||
                             (state_next == xadc_drp_pkg::seq_current_req);
            voltage_valid <= (state_next == xadc_drp_pkg::seq_voltage_send);
            current_valid <= (state_next == xadc_drp_pkg::seq_current_send);

            if (state_next == xadc_drp_pkg::seq_current_req) begin
                xadc_daddr <= xadc_drp_pkg::addr_current;
            end else if (state_next == xadc_drp_pkg::seq_idle) begin
                xadc_daddr <= xadc_drp_pkg::addr_voltage;
            end
        end
    end

    // Holding registers, stable while the stream waits for ready
    always_ff @(posedge xadc_dclk) begin
        if ((state == xadc_drp_pkg::seq_voltage_wait) && xadc_drdy) begin
            voltage_sample <= xadc_do;
        end
        if ((state == xadc_drp_pkg::seq_current_wait) && xadc_drdy) begin
            current_sample <= xadc_do;
        end
    end

endmodule

//--- xadc_sample_fifo.sv
`timescale 1ns/100ps

`include "xadc_params.svh"

module xadc_sample_fifo #(
    parameter int depth = `XADC_FIFO_DEPTH
) (
    input  logic                     xadc_dclk,
    input  logic                     arst_n,

    input  xadc_stream_pkg::sample_t in_data,
    input  logic                     in_valid,
    output logic                     in_ready,

    output xadc_stream_pkg::sample_t out_data,
    output logic                     out_valid,
    input  logic                     out_ready
);

    localparam int ptr_w = $clog2(depth);
    localparam int cnt_w = ptr_w + 1;
    localparam logic [cnt_w-1:0] depth_cnt = cnt_w'(depth);

    xadc_stream_pkg::sample_t mem [depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] count_next;
    logic             full_q;
    logic             empty_q;
    logic             push;
    logic             pop;

    // Count covers the buffer only, the output register sits behind it
    assign push     = in_valid && !full_q;
    assign pop      = !empty_q && (!out_valid || out_ready);
    assign in_ready = !full_q;

    always_comb begin
        case ({push, pop})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge xadc_dclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            full_q    <= 1'b0;
            empty_q   <= 1'b1;
            out_valid <= 1'b0;
        end else begin
            count   <= count_next;
            full_q  <= (count_next == depth_cnt);
            empty_q <= (count_next == '0);

            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end

            // Refill the output stage whenever it is free or being taken
            if (pop) begin
                rd_ptr    <= rd_ptr + 1'b1;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge xadc_dclk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
        if (pop) begin
            out_data <= mem[rd_ptr];
        end
    end

endmodule

//--- xadc_monitor_top.sv
`timescale 1ns/100ps

`include "xadc_params.svh"

module xadc_monitor_top (
    input  logic                            xadc_dclk,
    input  logic                            arst_n,

    // DRP port of the XADC primitive
    output logic [`XADC_DRP_ADDR_WIDTH-1:0] xadc_daddr,
    output logic                            xadc_den,
    input  logic                            xadc_drdy,
    input  logic [`XADC_DRP_DATA_WIDTH-1:0] xadc_do,
    input  logic                            xadc_eos,

    // Voltage channel stream
    output logic [`XADC_DRP_DATA_WIDTH-1:0] voltage_tdata,
    output logic                            voltage_tvalid,
    input  logic                            voltage_tready,

    // Current-monitor channel stream
    output logic [`XADC_DRP_DATA_WIDTH-1:0] current_tdata,
    output logic                            current_tvalid,
    input  logic                            current_tready
);

    xadc_drp_pkg::drp_addr_t  seq_daddr;
    xadc_stream_pkg::sample_t voltage_sample;
    logic                     voltage_valid;
    logic                     voltage_ready;
    xadc_stream_pkg::sample_t current_sample;
    logic                     current_valid;
    logic                     current_ready;

    assign xadc_daddr = seq_daddr;

    xadc_drp_sequencer sequencer (
        .xadc_dclk      (xadc_dclk),
        .arst_n         (arst_n),
        .xadc_eos       (xadc_eos),
        .xadc_drdy      (xadc_drdy),
        .xadc_do        (xadc_do),
        .xadc_daddr     (seq_daddr),
        .xadc_den       (xadc_den),
        .voltage_sample (voltage_sample),
        .voltage_valid  (voltage_valid),
        .voltage_ready  (voltage_ready),
        .current_sample (current_sample),
        .current_valid  (current_valid),
        .current_ready  (current_ready)
    );

    xadc_sample_fifo #(
        .depth (`XADC_FIFO_DEPTH)
    ) voltage_fifo (
        .xadc_dclk (xadc_dclk),
        .arst_n    (arst_n),
        .in_data   (voltage_sample),
        .in_valid  (voltage_valid),
        .in_ready  (voltage_ready),
        .out_data  (voltage_tdata),
        .out_valid (voltage_tvalid),
        .out_ready (voltage_tready)
    );

    xadc_sample_fifo #(
        .depth (`XADC_FIFO_DEPTH)
    ) current_fifo (
        .xadc_dclk (xadc_dclk),
        .arst_n    (arst_n),
        .in_data   (current_sample),
        .in_valid  (current_valid),
        .in_ready  (current_ready),
        .out_data  (current_tdata),
        .out_valid (current_tvalid),
        .out_ready (current_tready)
    );

endmodule

//--- tb_xadc_monitor.sv
`timescale 1ns/100ps

`include "xadc_params.svh"

module tb_xadc_monitor;

    localparam int max_records       = 64;
    localparam int cycles_per_record = 400;
    localparam int stall_eos_pulses  = 5;

    logic                            xadc_dclk;
    logic                            arst_n;
    logic [`XADC_DRP_ADDR_WIDTH-1:0] xadc_daddr;
    logic                            xadc_den;
    logic                            xadc_drdy;
    logic [`XADC_DRP_DATA_WIDTH-1:0] xadc_do;
    logic                            xadc_eos;
    logic [`XADC_DRP_DATA_WIDTH-1:0] voltage_tdata;
    logic                            voltage_tvalid;
    logic                            voltage_tready;
    logic [`XADC_DRP_DATA_WIDTH-1:0] current_tdata;
    logic                            current_tvalid;
    logic                            current_tready;

    logic [`XADC_DRP_DATA_WIDTH-1:0] voltage_word [max_records];
    logic [`XADC_DRP_DATA_WIDTH-1:0] current_word [max_records];
    int                              drdy_delay   [max_records];
    int                              ready_mode   [max_records];
    int                              num_records = 0;

    int   sink_mode         = 0;
    int   accepted_eos      = 0;
    int   voltage_den_count = 0;
    int   current_den_count = 0;
    int   drdy_count        = 0;
    int   voltage_seen      = 0;
    int   current_seen      = 0;
    int   cycle_count       = 0;
    int   cycle_limit       = 0;
    logic den_last          = 1'b0;

    xadc_monitor_top uut (
        .xadc_dclk      (xadc_dclk),
        .arst_n         (arst_n),
        .xadc_daddr     (xadc_daddr),
        .xadc_den       (xadc_den),
        .xadc_drdy      (xadc_drdy),
        .xadc_do        (xadc_do),
        .xadc_eos       (xadc_eos),
        .voltage_tdata  (voltage_tdata),
        .voltage_tvalid (voltage_tvalid),
        .voltage_tready (voltage_tready),
        .current_tdata  (current_tdata),
        .current_tvalid (current_tvalid),
        .current_tready (current_tready)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("error at %0d ns: %s, got 0x%0h, expected 0x%0h",
                               $time, what, actual, expected));
        end
    endtask

    // Taps x^17 + x^14 + 1
    // The new bit is the one taken
    function automatic logic [16:0] lfsr_next(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic load_golden();
        int                              fd;
        int                              fields;
        int                              delay;
        int                              mode;
        string                           line;
        logic [`XADC_DRP_DATA_WIDTH-1:0] vword;
        logic [`XADC_DRP_DATA_WIDTH-1:0] cword;
        fd = $fopen("xadc_monitor_golden.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open xadc_monitor_golden.txt for reading");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ((line.len() > 0) && (line.getc(0) != 8'h23)) begin
                fields = $sscanf(line, "%h %h %d %d", vword, cword, delay, mode);
                if (fields == 4) begin
                    if ((num_records >= max_records) || (delay < 1) || (mode > 2)) begin
                        fail_run($sformatf("golden record %0d is out of range", num_records));
                    end
                    voltage_word[num_records] = vword;
                    current_word[num_records] = cword;
                    drdy_delay[num_records]   = delay;
                    ready_mode[num_records]   = mode;
                    num_records++;
                end
            end
        end
        $fclose(fd);
        if (num_records == 0) begin
            fail_run("the golden file holds no records");
        end
    endtask

    // Called at a rising edge with the sequencer known to be idle
    task automatic start_sequence();
        #10;
        xadc_eos = 1'b1;
        @(posedge xadc_dclk);
        #10;
        xadc_eos = 1'b0;
        check_value(32'(xadc_den), 1, "xadc_den after eos in idle");
        check_value(32'(xadc_daddr), 32'(xadc_drp_pkg::addr_voltage), "first read address");
        // Second pulse lands while the voltage read is open
        @(posedge xadc_dclk);
        #10;
        xadc_eos = 1'b1;
        @(posedge xadc_dclk);
        #10;
        xadc_eos = 1'b0;
        @(negedge xadc_dclk);
    endtask

    // Current word delivered means the sequencer went idle before it
    task automatic wait_pair_closed(input int rec);
        @(posedge xadc_dclk);
        while (current_seen < rec) begin
            @(posedge xadc_dclk);
        end
    endtask

    task automatic pulse_eos_during_stall(input int rec);
        repeat (stall_eos_pulses) begin
            @(posedge xadc_dclk);
            #10;
            xadc_eos = 1'b1;
            @(posedge xadc_dclk);
            #10;
            xadc_eos = 1'b0;
            repeat (6) @(posedge xadc_dclk);
        end
        // Last started record sits in voltage send behind the full FIFO
        check_value(voltage_den_count, rec, "voltage reads started during the stall");
        check_value(current_den_count, rec - 1, "current reads during the stall");
        @(negedge xadc_dclk);
    endtask

    initial begin
        xadc_dclk = 1'b0;
        forever begin
            #50 xadc_dclk = ~xadc_dclk;
        end
    end

    // DRP model of the XADC answering one read at a time
    initial begin : drp_model
        int                              rec;
        logic [`XADC_DRP_DATA_WIDTH-1:0] word;
        xadc_drdy = 1'b0;
        xadc_do   = '0;
        forever begin
            @(negedge xadc_dclk);
            if (xadc_den) begin
                rec = drdy_count / 2;
                if (rec >= num_records) begin
                    fail_run("DRP read issued beyond the last golden record");
                end
                if ((drdy_count % 2) == 0) begin
                    check_value(32'(xadc_daddr), 32'(xadc_drp_pkg::addr_voltage),
                                "voltage read address");
                    word = voltage_word[rec];
                end else begin
                    check_value(32'(xadc_daddr), 32'(xadc_drp_pkg::addr_current),
                                "current read address");
                    word = current_word[rec];
                end
                repeat (drdy_delay[rec]) @(posedge xadc_dclk);
                #10;
                xadc_drdy = 1'b1;
                xadc_do   = word;
                drdy_count++;
                @(posedge xadc_dclk);
                #10;
                xadc_drdy = 1'b0;
                xadc_do   = '0;
            end
        end
    end

    // Mode 1 is LFSR back-pressure
    // Mode 2 holds the voltage stream off
    initial begin : stream_sink
        logic [16:0] lfsr;
        lfsr           = 17'd91606;
        voltage_tready = 1'b0;
        current_tready = 1'b0;
        forever begin
            @(posedge xadc_dclk);
            #10;
            case (sink_mode)
                1: begin
                    lfsr           = lfsr_next(lfsr);
                    voltage_tready = lfsr[0];
                    lfsr           = lfsr_next(lfsr);
                    current_tready = lfsr[0];
                end
                2: begin
                    voltage_tready = 1'b0;
                    current_tready = 1'b1;
                end
                default: begin
                    voltage_tready = 1'b1;
                    current_tready = 1'b1;
                end
            endcase
        end
    end

    always @(negedge xadc_dclk) begin
        if (arst_n) begin
            if (xadc_den) begin
                check_value(32'(den_last), 0, "xadc_den longer than one cycle");
                check_value(voltage_den_count + current_den_count, drdy_count,
                            "xadc_den while a read is pending");
                if (xadc_daddr == xadc_drp_pkg::addr_voltage) begin
                    voltage_den_count++;
                end else begin
                    current_den_count++;
                end
            end
            if (voltage_tvalid && voltage_tready) begin
                if (voltage_seen >= num_records) begin
                    fail_run("voltage stream delivered more words than were read");
                end
                check_value(32'(voltage_tdata), 32'(voltage_word[voltage_seen]), "voltage_tdata");
                voltage_seen++;
            end
            if (current_tvalid && current_tready) begin
                if (current_seen >= num_records) begin
                    fail_run("current stream delivered more words than were read");
                end
                check_value(32'(current_tdata), 32'(current_word[current_seen]), "current_tdata");
                current_seen++;
            end
        end
        den_last = xadc_den;
    end

    // Count of eos pulses sampled with no read pair open
    // A pair is open from its voltage den until its current word leaves the DUT
    always @(posedge xadc_dclk) begin
        if (arst_n && xadc_eos && (voltage_den_count == current_seen)) begin
            accepted_eos++;
        end
    end

    always @(posedge xadc_dclk) begin
        cycle_count++;
        if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
            fail_run($sformatf("timeout after %0d cycles with the sequencer in state %s",
                               cycle_count, uut.sequencer.state.name()));
        end
    end

    initial begin : main
        int rec;
        xadc_eos = 1'b0;
        arst_n   = 1'b0;
        load_golden();
        cycle_limit = cycles_per_record * num_records;
        repeat (3) @(posedge xadc_dclk);
        #10;
        arst_n = 1'b1;

        repeat (4) begin
            @(negedge xadc_dclk);
            check_value(32'(xadc_den), 0, "xadc_den after reset");
            check_value(32'(voltage_tvalid), 0, "voltage_tvalid after reset");
            check_value(32'(current_tvalid), 0, "current_tvalid after reset");
            check_value(32'(xadc_daddr), 32'(xadc_drp_pkg::addr_voltage), "daddr after reset");
        end

        for (rec = 0; rec < num_records; rec++) begin
            if ((sink_mode == 2) && (ready_mode[rec] != 2)) begin
                pulse_eos_during_stall(rec);
            end
            if ((sink_mode != 2) && (ready_mode[rec] == 2)) begin
                // Stall starts from an empty voltage FIFO
                @(posedge xadc_dclk);
                while (voltage_seen < rec) begin
                    @(posedge xadc_dclk);
                end
            end
            sink_mode = ready_mode[rec];
            wait_pair_closed(rec);
            start_sequence();
        end

        sink_mode = 0;
        @(posedge xadc_dclk);
        while ((voltage_seen < num_records) || (current_seen < num_records)) begin
            @(posedge xadc_dclk);
        end
        repeat (4) @(posedge xadc_dclk);
        #10;
        check_value(voltage_den_count, num_records, "number of voltage reads");
        check_value(current_den_count, num_records, "number of current reads");
        check_value(voltage_den_count, accepted_eos, "voltage reads against eos in idle");
        check_value(32'(voltage_tvalid), 0, "voltage_tvalid after the last word");
        check_value(32'(current_tvalid), 0, "current_tvalid after the last word");
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- xadc_monitor_golden.txt
# voltage_word current_word drdy_delay ready_mode (hex, hex, cycles, mode)
# ready_mode 0 always ready, 1 LFSR back-pressure, 2 voltage stream held off
7d30 1a20 1 0
7d40 1a60 2 0
ffff 0000 5 0
0000 ffff 20 0
a5a5 5a5a 3 0
7d20 1b10 1 0
7cf0 1c80 7 0
8010 2040 12 0
7d50 1d30 4 1
7d60 1e00 1 1
7d70 1e90 9 1
7d80 1f20 2 1
7d90 2000 15 1
7da0 2110 6 1
7db0 2230 1 1
7dc0 2350 18 1
7dd0 2470 3 1
7de0 2590 11 1
6e10 0f10 2 2
6e20 0f20 8 2
6e30 0f30 1 2
6e40 0f40 14 2
6e50 0f50 5 2
6e60 0f60 3 2
7e00 26b0 10 1
7e10 27c0 1 1
7e20 28d0 20 1
7e30 29e0 4 1
7e40 2af0 2 1
7e50 2c00 13 1
7e60 2d10 1 0
7e70 2e20 6 0
7e80 2f30 19 0
7e90 3040 2 0
7ea0 3150 8 0
7eb0 3260 1 0

//--- project.f
+incdir+.
xadc_drp_pkg.sv
xadc_stream_pkg.sv
xadc_drp_sequencer.sv
xadc_sample_fifo.sv
xadc_monitor_top.sv
tb_xadc_monitor.sv

//--- Makefile
# Verilator build and run of the XADC monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_xadc_monitor
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing

SOURCES := $(shell grep -v '^+' $(FILELIST)) xadc_params.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the test result
test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
